// ==== Bender.yml ====
package:
  name: ci_subsystem

sources:
  - common/ciPkg.sv
  - common/ciCommandIf.sv
  - customInstr/grayscaleUnit.sv
  - customInstr/customInstrUnit.sv
  - design/commandQueue.sv
  - design/hostCommandPort.sv
  - design/ciSubsystemTop.sv
  - target: test
    files:
      - dv/ciScoreboard.sv
      - dv/ciSubsystemTb.sv

// ==== common/ciCommandIf.sv ====
// one custom instruction with valid/ready flow control
interface ciCommandIf;

  logic             valid;
  logic             ready;
  ciPkg::ciCommand  command;

  // side that offers instructions
  modport source (
    output valid,
    output command,
    input  ready
  );

  // side that takes instructions
  modport sink (
    input  valid,
    input  command,
    output ready
  );

endinterface

// ==== common/ciPkg.sv ====
package ciPkg;

  localparam int ciWordWidth       = 32;
  localparam int ciIdWidth         = 8;
  localparam int ciAddrWidth       = 4;
  localparam int resetStretchWidth = 5;

  // custom instruction numbers
  localparam logic [ciIdWidth-1:0] ciSwapByteId  = 8'd1;
  localparam logic [ciIdWidth-1:0] ciGrayscaleId = 8'd12;

  // host registers at byte addresses
  localparam logic [ciAddrWidth-1:0] regOperandA = 4'h0;
  localparam logic [ciAddrWidth-1:0] regOperandB = 4'h4;
  localparam logic [ciAddrWidth-1:0] regCommand  = 4'h8;
  localparam logic [ciAddrWidth-1:0] regStatus   = 4'hC;

  typedef logic [ciWordWidth-1:0] ciWord;

  typedef struct packed {
    logic [ciIdWidth-1:0] ciN;
    ciWord                operandA;
    ciWord                operandB;
  } ciCommand;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565Pixel;

  // operand A as bytes for the swap and as pixels for grayscale
  typedef union packed {
    logic [3:0][7:0] bytes;
    struct packed {
      rgb565Pixel high;
      rgb565Pixel low;
    } pixels;
  } ciOperand;

endpackage

// ==== customInstr/customInstrUnit.sv ====
module customInstrUnit (
  input  logic         s_systemClock,
  input  logic         s_pllLocked,
  input  logic         resultReady,
  output logic         resultValid,
  output ciPkg::ciWord resultData,
  output logic         resultError,
  ciCommandIf.sink     queueOut
);

  import ciPkg::*;

  logic     start;
  ciOperand valueA;
  ciWord    valueB;
  logic     swapByteDone;
  ciWord    swapByteResult;
  ciWord    swapped;
  logic     grayscaleDone;
  ciWord    grayscaleResult;
  logic     ciDone;
  ciWord    ciResult;

  // take a new one when the holding stage is free or draining
  assign queueOut.ready = ~resultValid | resultReady;
  assign start          = queueOut.valid & queueOut.ready;

  assign valueA = queueOut.command.operandA;
  assign valueB = queueOut.command.operandB;

  always_comb begin
    if (valueB[0]) begin
      swapped = {valueA.bytes[2], valueA.bytes[3], valueA.bytes[0], valueA.bytes[1]};
    end else begin
      swapped = {valueA.bytes[0], valueA.bytes[1], valueA.bytes[2], valueA.bytes[3]};
    end
  end

  assign swapByteDone   = start & (queueOut.command.ciN == ciSwapByteId);
  assign swapByteResult = swapByteDone ? swapped : '0;

  grayscaleUnit grayscale (
    .start  (start),
    .ciN    (queueOut.command.ciN),
    .valueA (valueA),
    .done   (grayscaleDone),
    .result (grayscaleResult)
  );

  // wired-or of all units, idle ones drive zero
  assign ciDone   = swapByteDone | grayscaleDone;
  assign ciResult = swapByteResult | grayscaleResult;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resultValid <= 1'b0;
      resultError <= 1'b0;
    end else if (start) begin
      resultValid <= 1'b1;
      resultError <= ~ciDone;          // nobody claimed the number
    end else if (resultReady) begin
      resultValid <= 1'b0;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (start) resultData <= ciResult;
  end

  resultHeld : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    resultValid && !resultReady |=> $stable(resultData)
  );

endmodule

// ==== customInstr/grayscaleUnit.sv ====
module grayscaleUnit (
  input  logic                        start,
  input  logic [ciPkg::ciIdWidth-1:0] ciN,
  input  ciPkg::ciOperand             valueA,
  output logic                        done,
  output ciPkg::ciWord                result
);

  import ciPkg::*;

  rgb565Pixel pixel;
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  logic [15:0] weightedSum;
  logic [7:0] gray;

  assign pixel = valueA.pixels.low;     // only the low pixel

  // widen to 8 bits per channel
  assign red   = {pixel.red, 3'b000};
  assign green = {pixel.green, 2'b00};
  assign blue  = {pixel.blue, 3'b000};

  // weights add up to 256, so the sum fits in 16 bits
  assign weightedSum = red * 16'd54 + green * 16'd183 + blue * 16'd19;
  assign gray        = weightedSum[15:8];

  // zero unless addressed, keeps the or-combine clean
  assign done   = start & (ciN == ciGrayscaleId);
  assign result = done ? ciWord'(gray) : '0;

endmodule

// ==== design/ciSubsystemTop.sv ====
module ciSubsystemTop #(
  parameter int queueDepth = 4
) (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  input  logic                          wbCyc,
  input  logic                          wbStb,
  input  logic                          wbWe,
  input  logic [ciPkg::ciAddrWidth-1:0] wbAdr,
  input  ciPkg::ciWord                  wbDatIn,
  output ciPkg::ciWord                  wbDatOut,
  output logic                          wbAck,
  output logic                          resultValid,
  output ciPkg::ciWord                  resultData,
  output logic                          resultError,
  input  logic                          resultReady
);

  import ciPkg::*;

  logic [resetStretchWidth-1:0] resetCount;
  logic                         systemReady;
  logic [$clog2(queueDepth):0]  queueLevel;

  ciCommandIf queueIn ();
  ciCommandIf queueOut ();

  // stretch the pll lock, stops once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) resetCount <= '0;
    else if (!systemReady) resetCount <= resetCount + 1'b1;
  end

  assign systemReady = resetCount[resetStretchWidth-1];

  hostCommandPort #(.queueDepth(queueDepth)) hostPort (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReady   (systemReady),
    .wbCyc         (wbCyc),
    .wbStb         (wbStb),
    .wbWe          (wbWe),
    .wbAdr         (wbAdr),
    .wbDatIn       (wbDatIn),
    .queueLevel    (queueLevel),
    .wbDatOut      (wbDatOut),
    .wbAck         (wbAck),
    .queueIn       (queueIn.source)
  );

  commandQueue #(.queueDepth(queueDepth)) queue (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .level         (queueLevel),
    .queueIn       (queueIn.sink),
    .queueOut      (queueOut.source)
  );

  customInstrUnit ciUnit (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .resultReady   (resultReady),
    .resultValid   (resultValid),
    .resultData    (resultData),
    .resultError   (resultError),
    .queueOut      (queueOut.sink)
  );

  noAckInReset : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    wbAck |-> systemReady
  );

endmodule

// ==== design/commandQueue.sv ====
module commandQueue #(
  parameter int queueDepth = 4
) (
  input  logic                        s_systemClock,
  input  logic                        s_pllLocked,
  output logic [$clog2(queueDepth):0] level,
  ciCommandIf.sink                    queueIn,
  ciCommandIf.source                  queueOut
);

  import ciPkg::*;

  localparam int pointerWidth = $clog2(queueDepth);
  localparam int levelWidth   = pointerWidth + 1;

  ciCommand                entries [queueDepth];
  logic [pointerWidth-1:0] writePointer;
  logic [pointerWidth-1:0] readPointer;
  logic                    push;
  logic                    pop;

  assign queueIn.ready    = level != levelWidth'(queueDepth);
  assign queueOut.valid   = level != '0;
  assign queueOut.command = entries[readPointer];

  assign push = queueIn.valid & queueIn.ready;
  assign pop  = queueOut.valid & queueOut.ready;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      writePointer <= '0;
      readPointer  <= '0;
      level        <= '0;
    end else begin
      if (push) writePointer <= writePointer + 1'b1; // wraps, depth is a power of two
      if (pop) readPointer <= readPointer + 1'b1;
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;       // both or none
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (push) entries[writePointer] <= queueIn.command;
  end

  levelBound : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    level <= levelWidth'(queueDepth)
  );

endmodule

// ==== design/hostCommandPort.sv ====
module hostCommandPort #(
  parameter int queueDepth = 4
) (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  input  logic                          systemReady,
  input  logic                          wbCyc,
  input  logic                          wbStb,
  input  logic                          wbWe,
  input  logic [ciPkg::ciAddrWidth-1:0] wbAdr,
  input  ciPkg::ciWord                  wbDatIn,
  input  logic [$clog2(queueDepth):0]   queueLevel,
  output ciPkg::ciWord                  wbDatOut,
  output logic                          wbAck,
  ciCommandIf.source                    queueIn
);

  import ciPkg::*;

  localparam int levelWidth = $clog2(queueDepth) + 1;

  logic  request;
  logic  commandWrite;
  logic  queueFull;
  ciWord operandA;
  ciWord operandB;
  ciWord readData;
  ciWord statusWord;

  // a new access, not the cycle that is being acked
  assign request      = wbCyc & wbStb & ~wbAck & systemReady;
  assign commandWrite = request & wbWe & (wbAdr == regCommand);

  assign queueFull  = queueLevel == levelWidth'(queueDepth);
  assign statusWord = ciWord'({queueFull, 4'(queueLevel)});

  // offered as long as the host holds the write
  assign queueIn.valid   = commandWrite;
  assign queueIn.command = '{ciN: wbDatIn[ciIdWidth-1:0], operandA: operandA,
                             operandB: operandB};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      wbAck    <= 1'b0;
      operandA <= '0;
      operandB <= '0;
    end else begin
      wbAck <= request & (~commandWrite | queueIn.ready); // command waits for room
      if (request && wbWe && wbAdr == regOperandA) operandA <= wbDatIn;
      if (request && wbWe && wbAdr == regOperandB) operandB <= wbDatIn;
    end
  end

  always_comb begin
    case (wbAdr)
      regOperandA: readData = operandA;
      regOperandB: readData = operandB;
      regStatus:   readData = statusWord;
      default:     readData = '0;    // command and unmapped
    endcase
  end

  // read data lines up with the ack
  always_ff @(posedge s_systemClock) begin
    wbDatOut <= (request && !wbWe) ? readData : '0;
  end

  // classic ack is a single pulse per access
  ackSinglePulse : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    wbAck |=> !wbAck
  );

  // host must keep the command write until the queue takes it
  offerHeld : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    queueIn.valid && !queueIn.ready |=> queueIn.valid
  );

endmodule

// ==== dv/ciScoreboard.sv ====
module ciScoreboard (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  input  logic                          wbCyc,
  input  logic                          wbStb,
  input  logic                          wbWe,
  input  logic [ciPkg::ciAddrWidth-1:0] wbAdr,
  input  ciPkg::ciWord                  wbDatIn,
  input  ciPkg::ciWord                  wbDatOut,
  input  logic                          wbAck,
  input  logic                          resultValid,
  input  ciPkg::ciWord                  resultData,
  input  logic                          resultError,
  input  logic                          resultReady,
  output int                            commandCount,
  output int                            resultCount,
  output int                            errorCount,
  output int                            pendingCount
);

  import ciPkg::*;

  ciCommand issued [$];   // acked commands still waiting for a result
  ciWord    shadowA;
  ciWord    shadowB;

  // expected {error, data} from the instruction rules
  function automatic logic [ciWordWidth:0] referenceResult(ciCommand command);
    ciWord                a;
    int                   red;
    int                   green;
    int                   blue;
    logic [ciWordWidth:0] expected;
    a     = command.operandA;
    red   = int'(a[15:11]) << 3;
    green = int'(a[10:5]) << 2;
    blue  = int'(a[4:0]) << 3;
    if (command.ciN == ciSwapByteId && !command.operandB[0]) begin
      expected = {1'b0, a[7:0], a[15:8], a[23:16], a[31:24]};
    end else if (command.ciN == ciSwapByteId) begin
      expected = {1'b0, a[23:16], a[31:24], a[7:0], a[15:8]};  // swap inside halves
    end else if (command.ciN == ciGrayscaleId) begin
      expected = {1'b0, ciWord'((54 * red + 183 * green + 19 * blue) >> 8)};
    end else begin
      expected = {1'b1, 32'h0};
    end
    return expected;
  endfunction

  always @(posedge s_systemClock or negedge s_pllLocked) begin
    ciCommand             command;
    logic [ciWordWidth:0] expected;
    int                   errors;
    errors = 0;
    if (!s_pllLocked) begin
      issued.delete();
      shadowA = '0;
      shadowB = '0;
      commandCount <= 0;
      resultCount  <= 0;
      errorCount   <= 0;
    end else begin
      if (wbAck && wbWe && wbAdr == regOperandA) shadowA = wbDatIn;
      if (wbAck && wbWe && wbAdr == regOperandB) shadowB = wbDatIn;
      if (wbAck && wbWe && wbAdr == regCommand) begin
        issued.push_back('{ciN: wbDatIn[ciIdWidth-1:0], operandA: shadowA, operandB: shadowB});
        commandCount <= commandCount + 1;
      end
      if (resultValid && resultReady) begin
        resultCount <= resultCount + 1;
        if (issued.size() == 0) begin
          $display("result 0x%08h arrived with no command waiting for it", resultData);
          errors++;
        end else begin
          command  = issued.pop_front();
          expected = referenceResult(command);
          if (resultData !== expected[ciWordWidth-1:0]) begin
            $display("[ERROR] resultData (ciN 0x%02h): expected 0x%08h, got 0x%08h",
                     command.ciN, expected[ciWordWidth-1:0], resultData);
            errors++;
          end
          if (resultError !== expected[ciWordWidth]) begin
            $display("[ERROR] resultError (ciN 0x%02h): expected 0x%0h, got 0x%0h",
                     command.ciN, expected[ciWordWidth], resultError);
            errors++;
          end
          if (command.ciN == ciGrayscaleId && resultData[31:8] != '0) begin
            $display("[ERROR] resultData[31:8]: expected 0x000000, got 0x%06h", resultData[31:8]);
            errors++;
          end
        end
      end
      errorCount <= errorCount + errors;
    end
    pendingCount <= issued.size();
  end

endmodule

// ==== dv/ciSubsystemTb.sv ====
module ciSubsystemTb;

  import ciPkg::*;

  localparam int queueDepth    = 4;
  localparam int ackLimit      = 100;
  localparam int drainLimit    = 400;
  localparam int stretchCycles = 1 << (resetStretchWidth - 1);

  logic                   s_systemClock;
  logic                   s_pllLocked;
  logic                   wbCyc;
  logic                   wbStb;
  logic                   wbWe;
  logic [ciAddrWidth-1:0] wbAdr;
  ciWord                  wbDatIn;
  ciWord                  wbDatOut;
  logic                   wbAck;
  logic                   resultValid;
  ciWord                  resultData;
  logic                   resultError;
  logic                   resultReady;
  int                     commandCount;
  int                     resultCount;
  int                     checkErrors;
  int                     pendingCount;
  int                     localErrors;
  int                     errorsBefore;
  logic                   readyHold;
  logic                   throttle;
  logic                   readyBit  = 1'b1;
  logic [15:0]            dataLfsr  = 16'd44345;
  logic [15:0]            readyLfsr = 16'd44345;

  initial begin
    s_systemClock = 1'b0;
    forever #5 s_systemClock = ~s_systemClock;
  end

  ciSubsystemTop #(.queueDepth(queueDepth)) uut (.*);

  ciScoreboard scoreboard (.*, .errorCount(checkErrors));

  function automatic logic [15:0] lfsrStep(logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic ciWord randomBits(int count);
    ciWord value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      dataLfsr = lfsrStep(dataLfsr);
      value    = {value[30:0], dataLfsr[0]};
    end
    return value;
  endfunction

  always @(posedge s_systemClock) begin
    if (throttle) begin
      readyLfsr = lfsrStep(readyLfsr);
      readyBit <= readyLfsr[0];
    end
  end

  assign resultReady = throttle ? readyBit : readyHold;

  task automatic startAccess(input logic write, input logic [ciAddrWidth-1:0] address,
                             input ciWord data);
    @(posedge s_systemClock);
    wbCyc   <= 1'b1;
    wbStb   <= 1'b1;
    wbWe    <= write;
    wbAdr   <= address;
    wbDatIn <= data;
  endtask

  // waited is -1 on timeout
  task automatic waitAck(output int waited, output ciWord readData);
    logic seen;
    seen     = 1'b0;
    waited   = 0;
    readData = '0;
    while (!seen && waited < ackLimit) begin
      @(posedge s_systemClock);
      if (wbAck) begin
        seen     = 1'b1;
        readData = wbDatOut;
      end else begin
        waited++;
      end
    end
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
    if (!seen) begin
      $display("no wbAck within %0d cycles for address 0x%h", ackLimit, wbAdr);
      localErrors++;
      waited = -1;
    end
  endtask

  task automatic wbWrite(input logic [ciAddrWidth-1:0] address, input ciWord data);
    int    waited;
    ciWord unused;
    startAccess(1'b1, address, data);
    waitAck(waited, unused);
  endtask

  task automatic wbRead(input logic [ciAddrWidth-1:0] address, output ciWord data);
    int waited;
    startAccess(1'b0, address, '0);
    waitAck(waited, data);
  endtask

  task automatic expectWord(input string name, input ciWord expected, input ciWord actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, expected, actual);
      localErrors++;
    end
  endtask

  task automatic issueCommand(input logic [ciIdWidth-1:0] id, input ciWord a, input ciWord b);
    wbWrite(regOperandA, a);
    wbWrite(regOperandB, b);
    wbWrite(regCommand, ciWord'(id));
  endtask

  task automatic finishTest(input string name);
    int waited;
    int failures;
    waited = 0;
    @(posedge s_systemClock);  // scoreboard takes in the last ack
    while (pendingCount != 0 && waited < drainLimit) begin
      @(posedge s_systemClock);
      waited++;
    end
    if (pendingCount != 0) begin
      $display("%0d results still missing after %0d cycles", pendingCount, drainLimit);
      localErrors++;
    end
    failures = localErrors + checkErrors - errorsBefore;
    if (failures == 0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, failures);
    errorsBefore = localErrors + checkErrors;
  endtask

  initial begin
    int                        waited;
    ciWord                     data;
    logic [ciIdWidth-1:0]      id;
    logic [4:0][15:0]          corners;
    logic [4:0][ciIdWidth-1:0] unknownIds;
    s_pllLocked  = 1'b0;
    wbCyc        = 1'b0;
    wbStb        = 1'b0;
    wbWe         = 1'b0;
    wbAdr        = '0;
    wbDatIn      = '0;
    readyHold    = 1'b1;
    throttle     = 1'b0;
    localErrors  = 0;
    errorsBefore = 0;
    corners      = {16'h001F, 16'h07E0, 16'hF800, 16'hFFFF, 16'h0000};
    unknownIds   = {8'hFF, 8'd13, 8'd11, 8'd2, 8'd0};
    repeat (8) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;

    // status write has no effect so both operands stay 0
    startAccess(1'b1, regStatus, 32'hFFFF_FFFF);
    waitAck(waited, data);
    if (waited >= 0 && waited + 1 < stretchCycles) begin
      $display("wbAck came %0d cycles after reset release, too early", waited + 1);
      localErrors++;
    end
    wbRead(regOperandA, data);
    expectWord("wbDatOut (operand A)", '0, data);
    wbRead(regOperandB, data);
    expectWord("wbDatOut (operand B)", '0, data);
    finishTest("reset stretch");

    for (int i = 0; i < 8; i++) begin
      issueCommand(ciSwapByteId, randomBits(32), randomBits(31) << 1 | i[0]);
    end
    finishTest("byte swap");

    for (int i = 0; i < 5; i++) issueCommand(ciGrayscaleId, randomBits(16) << 16 | corners[i], '0);
    for (int i = 0; i < 6; i++) issueCommand(ciGrayscaleId, randomBits(32), randomBits(32));
    finishTest("grayscale");

    for (int i = 0; i < 5; i++) issueCommand(unknownIds[i], randomBits(32), randomBits(32));
    finishTest("unknown instruction");

    readyHold <= 1'b0;
    data = '0;
    for (int i = 0; i < 2 * queueDepth + 2 && data != (32'h10 | queueDepth); i++) begin
      issueCommand(ciSwapByteId, randomBits(32), randomBits(32));
      wbRead(regStatus, data);
    end
    expectWord("wbDatOut (status)", 32'h10 | queueDepth, data);
    wbWrite(regOperandA, randomBits(32));
    startAccess(1'b1, regCommand, ciWord'(ciGrayscaleId));
    waited = 0;
    repeat (20) begin
      @(posedge s_systemClock);
      if (wbAck) waited++;
    end
    if (waited != 0) begin
      $display("command write was acked while the queue was full");
      localErrors++;
    end
    readyHold <= 1'b1;
    waitAck(waited, data);
    finishTest("back-pressure and ordering");

    throttle <= 1'b1;
    for (int i = 0; i < 24; i++) begin
      case (2'(randomBits(2)))
        2'd0:    id = ciSwapByteId;
        2'd2:    id = 8'(randomBits(8));
        default: id = ciGrayscaleId;
      endcase
      issueCommand(id, randomBits(32), randomBits(32));
    end
    finishTest("random throttling");
    throttle <= 1'b0;

    if (resultCount != commandCount) begin
      $display("%0d results seen for %0d acked commands", resultCount, commandCount);
      localErrors++;
    end
    $display("commands %0d, results %0d, errors %0d", commandCount, resultCount,
             localErrors + checkErrors);
    if (localErrors + checkErrors != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
common/ciPkg.sv
common/ciCommandIf.sv
customInstr/grayscaleUnit.sv
customInstr/customInstrUnit.sv
design/commandQueue.sv
design/hostCommandPort.sv
design/ciSubsystemTop.sv
dv/ciScoreboard.sv
dv/ciSubsystemTb.sv
